/* rtl/ifu_pkg.sv */
package ifu_pkg;

	// datapath widths
	localparam int PC_W    = 32;
	localparam int IR_W    = 32;
	localparam int RFIDX_W = 5;

	// register indices with special meaning for jalr
	localparam logic [RFIDX_W-1:0] RF_X0 = 5'd0; // hard zero
	localparam logic [RFIDX_W-1:0] RF_X1 = 5'd1; // link reg, has its own read port

	// sequential pc step by instruction length
	localparam logic [PC_W-1:0] INCR_RV32 = 32'd4;
	localparam logic [PC_W-1:0] INCR_RV16 = 32'd2;

	// major opcodes, bits [6:0] of a 32-bit word
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	// fetch bus tracking, at most one request in flight
	typedef enum logic {
		FS_IDLE        = 1'b0,
		FS_OUTSTANDING = 1'b1
	} fetch_state_e;

endpackage

/* rtl/ifu_minidec.sv */
module ifu_minidec (
	input  logic [ifu_pkg::PC_W-1:0]    instr,      // raw word from the bus
	output logic                        dec_rv32,   // 32-bit encoding
	output logic                        dec_rs1en,
	output logic                        dec_rs2en,
	output logic [ifu_pkg::RFIDX_W-1:0] dec_rs1idx,
	output logic [ifu_pkg::RFIDX_W-1:0] dec_rs2idx,
	output logic                        dec_jal,
	output logic                        dec_jalr,
	output logic                        dec_bxx,    // conditional branch
	output logic [ifu_pkg::PC_W-1:0]    dec_bjp_imm // sign extended offset
);

	ifu_pkg::opcode_e opc;
	logic [ifu_pkg::PC_W-1:0] imm_j;
	logic [ifu_pkg::PC_W-1:0] imm_i;
	logic [ifu_pkg::PC_W-1:0] imm_b;

	// low two bits both set means full length word
	assign dec_rv32 = (instr[1:0] == 2'b11);
	assign opc      = ifu_pkg::opcode_e'(instr[6:0]);

	// immediates for the three jump/branch formats
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	assign imm_i = {{20{instr[31]}}, instr[31:20]};                      // jalr offset
	assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

	always_comb begin
		dec_rs1en   = 1'b0;
		dec_rs2en   = 1'b0;
		dec_rs1idx  = '0;
		dec_rs2idx  = '0;
		dec_jal     = 1'b0;
		dec_jalr    = 1'b0;
		dec_bxx     = 1'b0;
		dec_bjp_imm = '0;
		// 16-bit words leave everything low
		if (dec_rv32) begin
			dec_rs1idx = instr[19:15];
			dec_rs2idx = instr[24:20];
			case (opc)
				ifu_pkg::OP_JAL: begin
					dec_jal     = 1'b1;
					dec_bjp_imm = imm_j;
				end
				ifu_pkg::OP_JALR: begin
					dec_jalr    = 1'b1;
					dec_rs1en   = 1'b1; // base reg
					dec_bjp_imm = imm_i;
				end
				ifu_pkg::OP_BRANCH: begin
					dec_bxx     = 1'b1;
					dec_rs1en   = 1'b1;
					dec_rs2en   = 1'b1;
					dec_bjp_imm = imm_b;
				end
				ifu_pkg::OP_LOAD, ifu_pkg::OP_IMM: begin
					dec_rs1en = 1'b1;
				end
				ifu_pkg::OP_STORE, ifu_pkg::OP_REG: begin
					dec_rs1en = 1'b1;
					dec_rs2en = 1'b1;
				end
				// lui, auipc and unknown opcodes read nothing
				default: begin
					dec_rs1en = 1'b0;
				end
			endcase
		end
	end

endmodule

/* rtl/ifu_bpu.sv */
module ifu_bpu (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [ifu_pkg::PC_W-1:0]    pc,          // address of the word being decoded
	input  logic                        dec_jal,
	input  logic                        dec_jalr,
	input  logic                        dec_bxx,
	input  logic [ifu_pkg::PC_W-1:0]    dec_bjp_imm,
	input  logic [ifu_pkg::RFIDX_W-1:0] dec_rs1idx,
	input  logic                        dec_i_valid, // decoder input is a real response
	input  logic [ifu_pkg::PC_W-1:0]    rf2ifu_x1,
	input  logic [ifu_pkg::PC_W-1:0]    rf2ifu_rs1,
	output logic                        bpu_wait,
	output logic                        prdt_taken,
	output logic [ifu_pkg::PC_W-1:0]    prdt_pc_add_op1,
	output logic [ifu_pkg::PC_W-1:0]    prdt_pc_add_op2
);

	logic jalr_rs1x0;
	logic jalr_rs1x1;
	logic jalr_rs1xn;
	logic rs1xn_rd_r;   // general port read in progress
	logic rs1xn_rd_set;

	assign jalr_rs1x0 = (dec_rs1idx == ifu_pkg::RF_X0);
	assign jalr_rs1x1 = (dec_rs1idx == ifu_pkg::RF_X1);
	assign jalr_rs1xn = ~jalr_rs1x0 & ~jalr_rs1x1;

	// jumps always taken, branches only backward
	assign prdt_taken = dec_jal | dec_jalr | (dec_bxx & dec_bjp_imm[ifu_pkg::PC_W-1]);

	// first cycle of a jalr on xn stalls while the rf port is read
	assign rs1xn_rd_set = dec_i_valid & dec_jalr & jalr_rs1xn & ~rs1xn_rd_r;
	assign bpu_wait     = rs1xn_rd_set;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rs1xn_rd_r <= 1'b0;
		end else begin
			rs1xn_rd_r <= rs1xn_rd_set; // self clearing after one cycle
		end
	end

	// target adder operands
	always_comb begin
		if (dec_jalr) begin
			if (jalr_rs1x0) begin
				prdt_pc_add_op1 = '0;
			end else if (jalr_rs1x1) begin
				prdt_pc_add_op1 = rf2ifu_x1;
			end else begin
				prdt_pc_add_op1 = rf2ifu_rs1; // valid once the wait cycle is over
			end
		end else begin
			prdt_pc_add_op1 = pc; // jal and bxx are pc relative
		end
	end

	assign prdt_pc_add_op2 = dec_bjp_imm;

endmodule

/* rtl/ifu_pc_gen.sv */
module ifu_pc_gen (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [ifu_pkg::PC_W-1:0]  pc_rtvec,
	input  logic                      ifu_halt_req,
	input  logic                      pipe_flush_req,
	input  logic [ifu_pkg::PC_W-1:0]  pipe_flush_pc,
	input  logic                      ifu_req_ready,
	input  logic                      ifu_rsp_valid,
	input  logic [ifu_pkg::IR_W-1:0]  ifu_rsp_instr,
	input  logic [ifu_pkg::PC_W-1:0]  rf2ifu_x1,
	input  logic [ifu_pkg::PC_W-1:0]  rf2ifu_rs1,
	input  logic                      ir_i_ready,    // instruction stage can take a word
	output logic                      ifu_halt_ack,
	output logic                      ifu_req_valid,
	output logic [ifu_pkg::PC_W-1:0]  ifu_req_pc,
	output logic                      ifu_rsp_ready,
	output logic                      rsp_load,      // keep this response
	output logic                      rsp_taken,
	output logic                      rsp_rs1en,
	output logic                      rsp_rs2en,
	output logic                      rsp_rv32,
	output logic [ifu_pkg::PC_W-1:0]  inspect_pc
);

	logic reset_flag_r;  // high through reset, drops on first edge after
	logic reset_req_r;   // fetch from reset vector pending
	logic dly_flush_r;   // flush seen before the command went out
	logic flush_real;
	logic halt_ack_r;
	logic resume_r;      // refetch from pc_r after a halt
	logic resume_set;
	logic req_hsked;
	logic rsp_hsked;
	logic outs;
	logic no_outs;
	logic cmd_src;
	ifu_pkg::fetch_state_e state_r;
	logic [ifu_pkg::PC_W-1:0] pc_r;
	logic [ifu_pkg::PC_W-1:0] pc_nxt;
	logic [ifu_pkg::PC_W-1:0] pc_nxt_pre;
	logic [ifu_pkg::PC_W-1:0] pc_add_op1;
	logic [ifu_pkg::PC_W-1:0] pc_add_op2;

	logic dec_rv32;
	logic dec_rs1en;
	logic dec_rs2en;
	logic dec_jal;
	logic dec_jalr;
	logic dec_bxx;
	logic [ifu_pkg::RFIDX_W-1:0] dec_rs1idx;
	logic [ifu_pkg::PC_W-1:0]    dec_bjp_imm;
	logic bpu_wait;
	logic prdt_taken;
	logic [ifu_pkg::PC_W-1:0] prdt_pc_add_op1;
	logic [ifu_pkg::PC_W-1:0] prdt_pc_add_op2;

	ifu_minidec u_minidec (
		.instr       (ifu_rsp_instr),
		.dec_rv32    (dec_rv32),
		.dec_rs1en   (dec_rs1en),
		.dec_rs2en   (dec_rs2en),
		.dec_rs1idx  (dec_rs1idx),
		.dec_rs2idx  (),
		.dec_jal     (dec_jal),
		.dec_jalr    (dec_jalr),
		.dec_bxx     (dec_bxx),
		.dec_bjp_imm (dec_bjp_imm)
	);

	ifu_bpu u_bpu (
		.clk             (clk),
		.rst_n           (rst_n),
		.pc              (pc_r),
		.dec_jal         (dec_jal),
		.dec_jalr        (dec_jalr),
		.dec_bxx         (dec_bxx),
		.dec_bjp_imm     (dec_bjp_imm),
		.dec_rs1idx      (dec_rs1idx),
		.dec_i_valid     (ifu_rsp_valid),
		.rf2ifu_x1       (rf2ifu_x1),
		.rf2ifu_rs1      (rf2ifu_rs1),
		.bpu_wait        (bpu_wait),
		.prdt_taken      (prdt_taken),
		.prdt_pc_add_op1 (prdt_pc_add_op1),
		.prdt_pc_add_op2 (prdt_pc_add_op2)
	);

	assign outs       = (state_r == ifu_pkg::FS_OUTSTANDING);
	assign no_outs    = ~outs | ifu_rsp_valid;
	assign flush_real = pipe_flush_req | dly_flush_r;

	// under flush the response is dropped, so take it at once
	assign ifu_rsp_ready = outs & (flush_real | (ir_i_ready & ifu_req_ready & ~bpu_wait));
	assign rsp_hsked     = ifu_rsp_valid & ifu_rsp_ready;

	// new command: reset, flush, resume or the follow-on of a response
	assign cmd_src       = reset_req_r | flush_real | resume_r | (rsp_hsked & ~ifu_halt_req);
	assign ifu_req_valid = cmd_src & (~outs | rsp_hsked) & ~halt_ack_r & ~reset_flag_r;
	assign req_hsked     = ifu_req_valid & ifu_req_ready;

	// response taken but no command went out with it
	assign resume_set = rsp_hsked & ~req_hsked & ~flush_real;

	// sequential step or predicted target
	assign pc_add_op1 = prdt_taken ? prdt_pc_add_op1 : pc_r;
	assign pc_add_op2 = prdt_taken ? prdt_pc_add_op2 :
		(dec_rv32 ? ifu_pkg::INCR_RV32 : ifu_pkg::INCR_RV16);
	assign pc_nxt_pre = pc_add_op1 + pc_add_op2;

	always_comb begin
		if (pipe_flush_req) begin
			pc_nxt = pipe_flush_pc;
		end else if (dly_flush_r | resume_r) begin
			pc_nxt = pc_r;          // already holds the address to fetch
		end else if (reset_req_r) begin
			pc_nxt = pc_rtvec;
		end else begin
			pc_nxt = pc_nxt_pre;
		end
		pc_nxt[0] = 1'b0;          // halfword aligned
	end

	assign ifu_req_pc = pc_nxt;
	assign inspect_pc = pc_r;

	// pc_r tracks the address of the word in flight
	always_ff @(posedge clk) begin
		if (req_hsked | pipe_flush_req | resume_set) begin
			pc_r <= pc_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reset_flag_r <= 1'b1;
			reset_req_r  <= 1'b0;
			dly_flush_r  <= 1'b0;
			resume_r     <= 1'b0;
			halt_ack_r   <= 1'b0;
			state_r      <= ifu_pkg::FS_IDLE;
		end else begin
			reset_flag_r <= 1'b0;
			if (~reset_req_r & reset_flag_r) begin
				reset_req_r <= 1'b1;
			end else if (req_hsked) begin
				reset_req_r <= 1'b0;
			end
			if (pipe_flush_req & ~req_hsked) begin
				dly_flush_r <= 1'b1;  // hold until the flush command is accepted
			end else if (req_hsked) begin
				dly_flush_r <= 1'b0;
			end
			if (resume_set) begin
				resume_r <= 1'b1;
			end else if (req_hsked) begin
				resume_r <= 1'b0;
			end
			// ack only with the bus quiet, falls a cycle after the request
			if (ifu_halt_req & ~halt_ack_r & no_outs & ~ifu_req_valid) begin
				halt_ack_r <= 1'b1;
			end else if (~ifu_halt_req) begin
				halt_ack_r <= 1'b0;
			end
			if (req_hsked) begin
				state_r <= ifu_pkg::FS_OUTSTANDING;
			end else if (rsp_hsked) begin
				state_r <= ifu_pkg::FS_IDLE;
			end
		end
	end

	assign ifu_halt_ack = halt_ack_r;

	// side info for the instruction stage
	assign rsp_load  = rsp_hsked & ~flush_real;
	assign rsp_taken = prdt_taken;
	assign rsp_rs1en = dec_rs1en;
	assign rsp_rs2en = dec_rs2en;
	assign rsp_rv32  = dec_rv32;

endmodule

/* rtl/ifu_ir_stage.sv */
module ifu_ir_stage (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        rsp_load,
	input  logic                        rsp_taken,
	input  logic                        rsp_rs1en,
	input  logic                        rsp_rs2en,
	input  logic                        rsp_rv32,
	input  logic [ifu_pkg::IR_W-1:0]    ifu_rsp_instr,
	input  logic                        ifu_rsp_err,
	input  logic [ifu_pkg::PC_W-1:0]    inspect_pc,     // address of the word on the bus
	input  logic                        pipe_flush_req,
	input  logic                        ifu_o_ready,
	output logic                        ir_i_ready,
	output logic                        ifu_o_valid,
	output logic [ifu_pkg::IR_W-1:0]    ifu_o_ir,
	output logic [ifu_pkg::PC_W-1:0]    ifu_o_pc,
	output logic                        ifu_o_buserr,
	output logic                        ifu_o_prdt_taken,
	output logic [ifu_pkg::RFIDX_W-1:0] ifu_o_rs1idx,
	output logic [ifu_pkg::RFIDX_W-1:0] ifu_o_rs2idx
);

	logic valid_r;
	logic valid_clr;
	logic o_hsked;
	logic [ifu_pkg::IR_W-1:0]    ir_r;
	logic [ifu_pkg::PC_W-1:0]    pc_r;
	logic                        err_r;
	logic                        taken_r;
	logic [ifu_pkg::RFIDX_W-1:0] rs1idx_r;
	logic [ifu_pkg::RFIDX_W-1:0] rs2idx_r;

	assign o_hsked    = valid_r & ifu_o_ready;
	assign valid_clr  = o_hsked | (pipe_flush_req & valid_r); // drained or killed
	assign ir_i_ready = ~valid_r | valid_clr;                 // empty or emptying

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_r <= 1'b0;
		end else if (rsp_load) begin
			valid_r <= 1'b1; // a refill wins over the drain
		end else if (valid_clr) begin
			valid_r <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_load) begin
			ir_r[ifu_pkg::IR_W/2-1:0] <= ifu_rsp_instr[ifu_pkg::IR_W/2-1:0];
			pc_r    <= inspect_pc;
			err_r   <= ifu_rsp_err;
			taken_r <= rsp_taken;
		end
		// upper half untouched for 16-bit words
		if (rsp_load & rsp_rv32) begin
			ir_r[ifu_pkg::IR_W-1:ifu_pkg::IR_W/2] <= ifu_rsp_instr[ifu_pkg::IR_W-1:ifu_pkg::IR_W/2];
		end
		if (rsp_load & rsp_rs1en) begin
			rs1idx_r <= ifu_rsp_instr[19:15];
		end
		if (rsp_load & rsp_rs2en) begin
			rs2idx_r <= ifu_rsp_instr[24:20];
		end
	end

	assign ifu_o_valid      = valid_r;
	assign ifu_o_ir         = ir_r;
	assign ifu_o_pc         = pc_r;
	assign ifu_o_buserr     = err_r;
	assign ifu_o_prdt_taken = taken_r;
	assign ifu_o_rs1idx     = rs1idx_r;
	assign ifu_o_rs2idx     = rs2idx_r;

endmodule

/* rtl/ifu_top.sv */
module ifu_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [ifu_pkg::PC_W-1:0]    pc_rtvec,
	input  logic                        ifu_halt_req,
	input  logic                        ifu_req_ready,
	input  logic                        ifu_rsp_valid,
	input  logic                        ifu_rsp_err,
	input  logic [ifu_pkg::IR_W-1:0]    ifu_rsp_instr,
	input  logic                        ifu_o_ready,
	input  logic                        pipe_flush_req,
	input  logic [ifu_pkg::PC_W-1:0]    pipe_flush_pc,
	input  logic [ifu_pkg::PC_W-1:0]    rf2ifu_x1,
	input  logic [ifu_pkg::PC_W-1:0]    rf2ifu_rs1,
	output logic [ifu_pkg::PC_W-1:0]    inspect_pc,
	output logic                        ifu_halt_ack,
	output logic                        ifu_req_valid,
	output logic [ifu_pkg::PC_W-1:0]    ifu_req_pc,
	output logic                        ifu_rsp_ready,
	output logic                        ifu_o_valid,
	output logic [ifu_pkg::IR_W-1:0]    ifu_o_ir,
	output logic [ifu_pkg::PC_W-1:0]    ifu_o_pc,
	output logic                        ifu_o_buserr,
	output logic                        ifu_o_prdt_taken,
	output logic [ifu_pkg::RFIDX_W-1:0] ifu_o_rs1idx,
	output logic [ifu_pkg::RFIDX_W-1:0] ifu_o_rs2idx
);

	// pc generator to instruction stage
	logic ir_i_ready;
	logic rsp_load;
	logic rsp_taken;
	logic rsp_rs1en;
	logic rsp_rs2en;
	logic rsp_rv32;

	ifu_pc_gen u_pc_gen (
		.clk            (clk),
		.rst_n          (rst_n),
		.pc_rtvec       (pc_rtvec),
		.ifu_halt_req   (ifu_halt_req),
		.pipe_flush_req (pipe_flush_req),
		.pipe_flush_pc  (pipe_flush_pc),
		.ifu_req_ready  (ifu_req_ready),
		.ifu_rsp_valid  (ifu_rsp_valid),
		.ifu_rsp_instr  (ifu_rsp_instr),
		.rf2ifu_x1      (rf2ifu_x1),
		.rf2ifu_rs1     (rf2ifu_rs1),
		.ir_i_ready     (ir_i_ready),
		.ifu_halt_ack   (ifu_halt_ack),
		.ifu_req_valid  (ifu_req_valid),
		.ifu_req_pc     (ifu_req_pc),
		.ifu_rsp_ready  (ifu_rsp_ready),
		.rsp_load       (rsp_load),
		.rsp_taken      (rsp_taken),
		.rsp_rs1en      (rsp_rs1en),
		.rsp_rs2en      (rsp_rs2en),
		.rsp_rv32       (rsp_rv32),
		.inspect_pc     (inspect_pc)
	);

	// output register toward execute
	ifu_ir_stage u_ir_stage (
		.clk              (clk),
		.rst_n            (rst_n),
		.rsp_load         (rsp_load),
		.rsp_taken        (rsp_taken),
		.rsp_rs1en        (rsp_rs1en),
		.rsp_rs2en        (rsp_rs2en),
		.rsp_rv32         (rsp_rv32),
		.ifu_rsp_instr    (ifu_rsp_instr),
		.ifu_rsp_err      (ifu_rsp_err),
		.inspect_pc       (inspect_pc),
		.pipe_flush_req   (pipe_flush_req),
		.ifu_o_ready      (ifu_o_ready),
		.ir_i_ready       (ir_i_ready),
		.ifu_o_valid      (ifu_o_valid),
		.ifu_o_ir         (ifu_o_ir),
		.ifu_o_pc         (ifu_o_pc),
		.ifu_o_buserr     (ifu_o_buserr),
		.ifu_o_prdt_taken (ifu_o_prdt_taken),
		.ifu_o_rs1idx     (ifu_o_rs1idx),
		.ifu_o_rs2idx     (ifu_o_rs2idx)
	);

endmodule

/* tb/ifu_mem_model.sv */
module ifu_mem_model (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req_valid,
	output logic                     req_ready,
	input  logic [ifu_pkg::PC_W-1:0] req_pc,
	output logic                     rsp_valid,
	input  logic                     rsp_ready,
	output logic [ifu_pkg::IR_W-1:0] rsp_instr,
	output logic                     rsp_err,
	input  logic [ifu_pkg::PC_W-1:0] chk_addr,  // lookup port for the checker
	output logic [ifu_pkg::IR_W-1:0] chk_word,
	output logic                     chk_err
);
	timeunit 1ns;
	timeprecision 1ps;

	integer seed = 60;
	ifu_pkg::fetch_state_e st;
	logic [ifu_pkg::PC_W-1:0] pc_q; // address being served
	logic [1:0] wait_cnt;           // response latency

	// program image, a pure function of the whole address
	function automatic logic [31:0] prog_word(input logic [31:0] addr);
		logic [31:0] h;
		logic [10:0] joff;
		logic [11:0] imm;
		logic [12:0] boff;
		h = (addr >> 1) * 32'h9E37_79B1;
		h = h ^ (h >> 15);
		joff = {6'b0, h[3:0], 1'b0} + 11'd8;
		boff = {8'b0, h[3:0], 1'b0} + 13'd4;
		case (h[31:28])
			4'd5: return {7'b0, addr[7:3], addr[11:7], 3'b000, 5'd4, ifu_pkg::OP_REG};
			4'd6: return {h[19:0], 5'd6, ifu_pkg::OP_LUI};
			4'd7: return {h[15:0], h[29:16], 2'b01};  // 16-bit
			4'd8: return {h[31:16], h[15:2], 2'b10};  // 16-bit
			4'd9: return {1'b0, joff[10:1], 1'b0, 8'h00, 5'd1, ifu_pkg::OP_JAL};
			4'd10: begin
				imm = 12'h100 + {2'b0, h[9:1], 1'b0}; // absolute target on x0
				return {imm, 5'd0, 3'b000, 5'd0, ifu_pkg::OP_JALR};
			end
			4'd11: begin
				imm = {{6{h[6]}}, h[5:1], 1'b0};
				return {imm, 5'd1, 3'b000, 5'd0, ifu_pkg::OP_JALR};
			end
			4'd12: begin
				imm = {{6{h[6]}}, h[5:1], 1'b0};
				return {imm, 5'd5, 3'b000, 5'd0, ifu_pkg::OP_JALR}; // general rs1
			end
			4'd13: begin
				return {boff[12], boff[10:5], 5'd2, 5'd3, 3'b000, boff[4:1], boff[11],
					ifu_pkg::OP_BRANCH};
			end
			4'd14: begin
				boff = 13'd0 - boff; // backward
				return {boff[12], boff[10:5], 5'd2, 5'd3, 3'b001, boff[4:1], boff[11],
					ifu_pkg::OP_BRANCH};
			end
			default: return {h[27:16], addr[8:4], 3'b000, 5'd3, ifu_pkg::OP_IMM};
		endcase
	endfunction

	// bus error region 0x300..0x37f
	function automatic logic prog_err(input logic [31:0] addr);
		return addr[31:7] == 25'h6;
	endfunction

	assign chk_word = prog_word(chk_addr);
	assign chk_err  = prog_err(chk_addr);

	always @(posedge clk) begin
		if (!rst_n) begin
			st        <= ifu_pkg::FS_IDLE;
			req_ready <= 1'b0;
			rsp_valid <= 1'b0;
			wait_cnt  <= 2'd0;
		end else if (st == ifu_pkg::FS_IDLE) begin
			if (req_valid && req_ready) begin
				pc_q      <= req_pc;
				st        <= ifu_pkg::FS_OUTSTANDING;
				req_ready <= 1'b0;
				wait_cnt  <= 2'($random(seed));
			end else begin
				req_ready <= ($random(seed) & 3) != 0;
			end
		end else if (rsp_valid && rsp_ready) begin
			rsp_valid <= 1'b0;
			if (req_valid && req_ready) begin // follow-on command
				pc_q      <= req_pc;
				req_ready <= 1'b0;
				wait_cnt  <= 2'($random(seed));
			end else begin
				st        <= ifu_pkg::FS_IDLE;
				req_ready <= ($random(seed) & 3) != 0;
			end
		end else if (!rsp_valid) begin
			if (wait_cnt == 2'd0) begin
				rsp_valid <= 1'b1;
				rsp_instr <= prog_word(pc_q);
				rsp_err   <= prog_err(pc_q);
				req_ready <= 1'b1; // ready for the next address with the response
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end
	end

endmodule

/* tb/tb_ifu.sv */
module tb_ifu;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] RTVEC    = 32'h0000_0100;
	localparam logic [31:0] X1_VAL   = 32'h0000_0200;
	localparam logic [31:0] RS1_VAL  = 32'h0000_0300;
	localparam logic [31:0] FLUSH_PC = 32'h0000_0455; // odd target so bit 0 gets cleared
	localparam int N_INSTR    = 400;
	localparam int TIMEOUT_NS = (N_INSTR * 30 + 500) * 20;

	integer seed = 60;
	int delivered = 0;

	logic clk;
	logic rst_n;
	logic [31:0] pc_rtvec;
	logic ifu_halt_req;
	logic ifu_req_ready;
	logic ifu_rsp_valid;
	logic ifu_rsp_err;
	logic [31:0] ifu_rsp_instr;
	logic ifu_o_ready;
	logic pipe_flush_req;
	logic [31:0] pipe_flush_pc;
	logic [31:0] rf2ifu_x1;
	logic [31:0] rf2ifu_rs1;
	logic [31:0] inspect_pc;
	logic ifu_halt_ack;
	logic ifu_req_valid;
	logic [31:0] ifu_req_pc;
	logic ifu_rsp_ready;
	logic ifu_o_valid;
	logic [31:0] ifu_o_ir;
	logic [31:0] ifu_o_pc;
	logic ifu_o_buserr;
	logic ifu_o_prdt_taken;
	logic [4:0] ifu_o_rs1idx;
	logic [4:0] ifu_o_rs2idx;
	logic [31:0] chk_word;
	logic chk_err;

	ifu_top dut (.*);

	ifu_mem_model mem (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_valid (ifu_req_valid),
		.req_ready (ifu_req_ready),
		.req_pc    (ifu_req_pc),
		.rsp_valid (ifu_rsp_valid),
		.rsp_ready (ifu_rsp_ready),
		.rsp_instr (ifu_rsp_instr),
		.rsp_err   (ifu_rsp_err),
		.chk_addr  (ifu_o_pc),
		.chk_word  (chk_word),
		.chk_err   (chk_err)
	);

	task automatic report_mismatch(input string msg);
		$display("Mismatch at %0t ns: %s", $time, msg);
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	// static prediction rules giving {taken, next pc}
	function automatic logic [32:0] predict_next(input logic [31:0] pc, input logic [31:0] w);
		logic [31:0] imm;
		logic [31:0] base;
		if (w[1:0] != 2'b11) return {1'b0, pc + 32'd2};
		case (w[6:0])
			ifu_pkg::OP_JAL: begin
				imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
				return {1'b1, pc + imm};
			end
			ifu_pkg::OP_JALR: begin
				imm  = {{20{w[31]}}, w[31:20]};
				base = (w[19:15] == 5'd0) ? 32'd0 : (w[19:15] == 5'd1) ? X1_VAL : RS1_VAL;
				return {1'b1, (base + imm) & ~32'd1};
			end
			ifu_pkg::OP_BRANCH: begin
				imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				if (imm[31]) return {1'b1, pc + imm}; // backward taken
				return {1'b0, pc + 32'd4};
			end
			default: return {1'b0, pc + 32'd4};
		endcase
	endfunction

	// {rs1 used, rs2 used} for a 32-bit word
	function automatic logic [1:0] reg_use(input logic [31:0] w);
		if (w[1:0] != 2'b11) return 2'b00;
		case (w[6:0])
			ifu_pkg::OP_JALR, ifu_pkg::OP_LOAD, ifu_pkg::OP_IMM: return 2'b10;
			ifu_pkg::OP_BRANCH, ifu_pkg::OP_STORE, ifu_pkg::OP_REG: return 2'b11;
			default: return 2'b00;
		endcase
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		ifu_o_ready <= ($random(seed) & 3) != 0; // execute stalls now and then
	end

	task automatic issue_flush(input logic [31:0] target);
		pipe_flush_req <= 1'b1;
		pipe_flush_pc  <= target;
		@(posedge clk);
		pipe_flush_req <= 1'b0;
	endtask

	task automatic hold_halt(input int cycles);
		ifu_halt_req <= 1'b1;
		@(negedge clk);
		while (!ifu_halt_ack) @(negedge clk);
		repeat (cycles) @(posedge clk);
		ifu_halt_req <= 1'b0;
	endtask

	// reference pc model and checks sampled mid cycle
	logic [31:0] exp_pc = RTVEC;
	logic [32:0] nxt;
	logic [32:0] bus_nxt;
	logic [1:0] use_q;
	logic seen_req = 1'b0;
	logic stall_q = 1'b0;
	logic flush_pend = 1'b0; // flush seen, its command not yet taken
	logic rsp_wait_q = 1'b0; // response already waiting last cycle
	logic [31:0] ir_q;
	logic [31:0] opc_q;

	always @(negedge clk) begin
		if (rst_n) begin
			if (!seen_req) begin
				assert (!ifu_o_valid) else report_mismatch("output valid before first request");
				if (ifu_req_valid) begin
					assert (ifu_req_pc == RTVEC)
						else report_mismatch($sformatf("first req pc %h", ifu_req_pc));
					seen_req = 1'b1;
				end
			end
			assert (!(ifu_halt_ack && ifu_req_valid))
				else report_mismatch("request issued while halt acknowledged");
			// word on the bus follows the one held in the stage
			if (ifu_rsp_valid && !flush_pend) begin
				bus_nxt = ifu_o_valid ? predict_next(ifu_o_pc, chk_word) : {1'b0, exp_pc};
				assert (inspect_pc == bus_nxt[31:0])
					else report_mismatch($sformatf("inspect_pc %h expected %h",
						inspect_pc, bus_nxt[31:0]));
			end
			// full stage stalls the bus
			if (ifu_o_valid && !ifu_o_ready && !pipe_flush_req && !flush_pend) begin
				assert (!ifu_rsp_ready)
					else report_mismatch("response taken while output is stalled");
			end
			// jalr on a general register waits one cycle for the rf read
			if (ifu_rsp_valid && !rsp_wait_q && !pipe_flush_req && !flush_pend &&
					ifu_rsp_instr[6:0] == ifu_pkg::OP_JALR &&
					ifu_rsp_instr[19:16] != 4'd0) begin
				assert (!ifu_rsp_ready)
					else report_mismatch("no register read wait for jalr");
			end
			if (stall_q) begin // held under back-pressure
				assert (ifu_o_valid && ifu_o_ir == ir_q && ifu_o_pc == opc_q)
					else report_mismatch("output changed under back-pressure");
			end
			if (ifu_o_valid && ifu_o_ready) begin
				nxt   = predict_next(ifu_o_pc, chk_word);
				use_q = reg_use(chk_word);
				assert (ifu_o_pc == exp_pc)
					else report_mismatch($sformatf("pc %h expected %h", ifu_o_pc, exp_pc));
				if (chk_word[1:0] == 2'b11) begin
					assert (ifu_o_ir == chk_word)
						else report_mismatch($sformatf("ir %h expected %h", ifu_o_ir, chk_word));
				end else begin
					assert (ifu_o_ir[15:0] == chk_word[15:0])
						else report_mismatch($sformatf("ir16 %h expected %h",
							ifu_o_ir[15:0], chk_word[15:0]));
				end
				assert (ifu_o_buserr == chk_err)
					else report_mismatch($sformatf("buserr at %h", ifu_o_pc));
				assert (ifu_o_prdt_taken == nxt[32])
					else report_mismatch($sformatf("prediction at %h", ifu_o_pc));
				if (use_q[1]) begin
					assert (ifu_o_rs1idx == chk_word[19:15])
						else report_mismatch($sformatf("rs1idx at %h", ifu_o_pc));
				end
				if (use_q[0]) begin
					assert (ifu_o_rs2idx == chk_word[24:20])
						else report_mismatch($sformatf("rs2idx at %h", ifu_o_pc));
				end
				exp_pc = nxt[31:0];
				delivered++;
			end
			if (pipe_flush_req) exp_pc = pipe_flush_pc & ~32'd1; // redirect wins
			if (ifu_req_valid && ifu_req_ready) flush_pend = 1'b0;
			if (pipe_flush_req && !(ifu_req_valid && ifu_req_ready)) flush_pend = 1'b1;
			rsp_wait_q = ifu_rsp_valid && !ifu_rsp_ready;
			stall_q = ifu_o_valid && !ifu_o_ready && !pipe_flush_req;
			ir_q    = ifu_o_ir;
			opc_q   = ifu_o_pc;
		end
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: only %0d of %0d instructions delivered", delivered, N_INSTR);
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_n          = 1'b0;
		pc_rtvec       = RTVEC;
		ifu_halt_req   = 1'b0;
		ifu_o_ready    = 1'b0;
		pipe_flush_req = 1'b0;
		pipe_flush_pc  = 32'd0;
		rf2ifu_x1      = X1_VAL;
		rf2ifu_rs1     = RS1_VAL;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		wait (delivered >= 80);
		@(posedge clk);
		issue_flush(FLUSH_PC);
		wait (delivered >= 150);
		@(posedge clk);
		hold_halt(6);
		wait (delivered >= 230);
		@(posedge clk);
		issue_flush(FLUSH_PC + 32'h40);
		wait (delivered >= N_INSTR);
		@(posedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* build.f */
rtl/ifu_pkg.sv
rtl/ifu_minidec.sv
rtl/ifu_bpu.sv
rtl/ifu_pc_gen.sv
rtl/ifu_ir_stage.sv
rtl/ifu_top.sv
tb/ifu_mem_model.sv
tb/tb_ifu.sv

/* Makefile */
# Verilator build and run of the instruction fetch testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
